// ==== vlog.f ====
+incdir+common
+incdir+testbench
common/pet_pkg.sv
logic/bus_cycle_control.sv
address_decoding/memory_control.sv
address_decoding/address_decoding.sv
logic/pet_bus_top.sv
testbench/pet_bus_tb.sv

// ==== Makefile ====
# Verilator build and run for the PET bus decoder testbench

SIM = obj_dir/pet_bus_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ns -f vlog.f \
		--top-module pet_bus_tb -o pet_bus_sim

# Pass only when the testbench prints its pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== testbench/pet_bus_tests.svh ====
// Directed tests for the PET bus decoder
// Bus cycle driver, a reference model of the PET memory map and
// one task per tested behavior

// Range boundaries of the PET map
localparam logic [15:0] map_edges [16] = '{
    16'h7FFF, 16'h8000, 16'h8EFF, 16'h8F00, 16'h8FFF, 16'h9000, 16'hE80F, 16'hE810,
    16'hE81F, 16'hE820, 16'hE83F, 16'hE840, 16'hE87F, 16'hE880, 16'hE8FF, 16'hE900
};

// Expected flags with expansion off
function automatic logic [8:0] pet_map_flags(input logic [15:0] addr);
    if (addr <= 16'h7FFF) return flags_ram;
    if (addr >= 16'h8F00 && addr <= 16'h8FFF) return flags_sid;
    if (addr >= 16'h8000 && addr <= 16'h8EFF) return flags_vram;
    if (addr >= 16'hE810 && addr <= 16'hE81F) return flags_pia1;
    if (addr >= 16'hE820 && addr <= 16'hE83F) return flags_pia2;
    if (addr >= 16'hE840 && addr <= 16'hE87F) return flags_via;
    if (addr >= 16'hE880 && addr <= 16'hE8FF) return flags_crtc;
    return flags_rom;
endfunction

function automatic logic [8:0] dut_flags();
    return {ram_en, is_vram, is_readonly, sid_en, pia1_en, pia2_en, via_en, crtc_en, io_en};
endfunction

task automatic decode_and_check(input logic [15:0] addr, input logic [8:0] exp_flags,
                                input logic [16:0] exp_ram_addr);
    @(negedge sys_clock);
    cpu_addr = addr;
    @(negedge sys_clock);
    check_equal($sformatf("enables at %h", addr), 32'(dut_flags()), 32'(exp_flags));
    check_equal($sformatf("ram_addr_o at %h", addr), 32'(ram_addr), 32'(exp_ram_addr));
endtask

// Phi2 high for 3 clocks, then low with the address held for 2 more
task automatic bus_cycle(input logic [15:0] addr, input logic rw, input logic [7:0] data,
                         output int we_cycles, output int oe_cycles);
    we_cycles = 0;
    oe_cycles = 0;
    @(negedge sys_clock);
    cpu_addr = addr;
    cpu_rw   = rw;
    cpu_data = data;
    cpu_phi2 = 1'b1;
    for (int i = 0; i < 5; i++) begin
        @(negedge sys_clock);
        if (ram_we) we_cycles++;
        if (ram_oe) oe_cycles++;
        if (i == 2) cpu_phi2 = 1'b0;
    end
    cpu_rw = 1'b1;  // Idle bus reads
endtask

task automatic reset_and_map_decode();
    logic [15:0] addr;
    check_equal("ram_we_o", 32'(ram_we), 32'd0);
    check_equal("ram_oe_o", 32'(ram_oe), 32'd0);
    @(negedge sys_clock);
    cpu_be = 1'b1;
    for (int i = 0; i < 16; i++) begin
        decode_and_check(map_edges[i], pet_map_flags(map_edges[i]), {1'b0, map_edges[i]});
    end
    // Bit 16 stays clear while expansion is off
    repeat (200) begin
        random_address(addr);
        decode_and_check(addr, pet_map_flags(addr), {1'b0, addr});
    end
endtask

task automatic write_cycles();
    int we_cycles;
    int oe_cycles;
    bus_cycle(16'h1234, 1'b0, 8'h5A, we_cycles, oe_cycles);
    check_equal("ram_we_o cycles on RAM write", we_cycles, 1);
    check_equal("ram_oe_o cycles on RAM write", oe_cycles, 0);
    bus_cycle(16'hC000, 1'b0, 8'hA5, we_cycles, oe_cycles);
    check_equal("ram_we_o cycles on ROM write", we_cycles, 0);
    bus_cycle(16'h2000, 1'b1, 8'h00, we_cycles, oe_cycles);
    check_equal("ram_we_o cycles on RAM read", we_cycles, 0);
    check_equal("ram_oe_o cycles on RAM read", oe_cycles, 3);  // Whole phi2 high phase
endtask

task automatic bus_disabled();
    int we_cycles;
    int oe_cycles;
    @(negedge sys_clock);
    cpu_be = 1'b0;
    decode_and_check(16'h0100, flags_none, {1'b0, 16'h0100});
    decode_and_check(16'h8000, flags_none, {1'b0, 16'h8000});
    decode_and_check(16'h8F10, flags_none, {1'b0, 16'h8F10});
    decode_and_check(16'hE810, flags_none, {1'b0, 16'hE810});
    decode_and_check(16'hE880, flags_none, {1'b0, 16'hE880});
    decode_and_check(16'hC000, flags_none, {1'b0, 16'hC000});
    bus_cycle(16'h0100, 1'b0, 8'h11, we_cycles, oe_cycles);
    check_equal("ram_we_o cycles with bus disabled", we_cycles, 0);
    @(negedge sys_clock);
    cpu_be = 1'b1;
endtask

task automatic expansion_banks();
    int we_cycles;
    int oe_cycles;
    bus_cycle(`PET_MEM_CTL_ADDR, 1'b0, 8'h8C, we_cycles, oe_cycles);  // Enable, both selects
    decode_and_check(16'h9000, flags_ram, {1'b1, 1'b1, 15'h1000});
    decode_and_check(16'hE000, flags_ram, {1'b1, 1'b1, 15'h6000});
    bus_cycle(16'h9000, 1'b0, 8'h33, we_cycles, oe_cycles);
    check_equal("ram_we_o cycles on lower bank write", we_cycles, 1);
    bus_cycle(16'hE000, 1'b0, 8'h66, we_cycles, oe_cycles);
    check_equal("ram_we_o cycles on upper bank write", we_cycles, 1);
endtask

task automatic protect_and_peek();
    int we_cycles;
    int oe_cycles;
    bus_cycle(`PET_MEM_CTL_ADDR, 1'b0, 8'hE3, we_cycles, oe_cycles);  // Peeks and protects
    decode_and_check(16'h8400, flags_vram, {1'b0, 16'h8400});
    decode_and_check(16'hE810, flags_pia1, {1'b0, 16'hE810});
    decode_and_check(16'hA000, flags_rom, {1'b1, 1'b0, 15'h2000});
    bus_cycle(16'hA000, 1'b0, 8'h44, we_cycles, oe_cycles);
    check_equal("ram_we_o cycles on protected bank", we_cycles, 0);
endtask

task automatic reset_clears_expansion();
    apply_reset();
    check_equal("ram_we_o after reset", 32'(ram_we), 32'd0);
    check_equal("ram_oe_o after reset", 32'(ram_oe), 32'd0);
    decode_and_check(16'hA000, flags_rom, {1'b0, 16'hA000});
endtask

// ==== testbench/pet_bus_tb.sv ====
// PET bus decoding testbench
// Drives CPU bus cycles into the decoder top level and checks the
// device enables, the RAM address and the RAM strobes

`timescale 1ns/1ns

`include "pet_consts.svh"

module pet_bus_tb;

    localparam int cycle_limit = 2000;  // Well above the full test sequence

    // Flag order: ram, vram, readonly, sid, pia1, pia2, via, crtc, io
    localparam logic [8:0] flags_none = 9'b000_000_000;
    localparam logic [8:0] flags_ram  = 9'b100_000_000;
    localparam logic [8:0] flags_vram = 9'b110_000_000;
    localparam logic [8:0] flags_rom  = 9'b101_000_000;
    localparam logic [8:0] flags_sid  = 9'b000_100_000;
    localparam logic [8:0] flags_pia1 = 9'b000_010_001;
    localparam logic [8:0] flags_pia2 = 9'b000_001_001;
    localparam logic [8:0] flags_via  = 9'b000_000_101;
    localparam logic [8:0] flags_crtc = 9'b000_000_010;

    logic                           sys_clock = 1'b0;
    logic                           reset;
    logic                           cpu_be;
    logic                           cpu_phi2;
    logic                           cpu_rw;
    logic [`PET_ADDR_WIDTH-1:0]     cpu_addr;
    logic [`PET_DATA_WIDTH-1:0]     cpu_data;
    logic [`PET_RAM_ADDR_WIDTH-1:0] ram_addr;
    logic                           ram_oe;
    logic                           ram_we;
    logic                           ram_en;
    logic                           is_vram;
    logic                           is_readonly;
    logic                           sid_en;
    logic                           pia1_en;
    logic                           pia2_en;
    logic                           via_en;
    logic                           crtc_en;
    logic                           io_en;
    logic [15:0]                    lfsr_state = 16'd39;
    int                             cycle_count = 0;

    pet_bus_top u_pet_bus_top (
        .sys_clock_i   (sys_clock),
        .reset_i       (reset),
        .cpu_be_i      (cpu_be),
        .cpu_phi2_i    (cpu_phi2),
        .cpu_rw_i      (cpu_rw),
        .cpu_addr_i    (cpu_addr),
        .cpu_data_i    (cpu_data),
        .ram_addr_o    (ram_addr),
        .ram_oe_o      (ram_oe),
        .ram_we_o      (ram_we),
        .ram_en_o      (ram_en),
        .is_vram_o     (is_vram),
        .is_readonly_o (is_readonly),
        .sid_en_o      (sid_en),
        .pia1_en_o     (pia1_en),
        .pia2_en_o     (pia2_en),
        .via_en_o      (via_en),
        .crtc_en_o     (crtc_en),
        .io_en_o       (io_en)
    );

    always #4 sys_clock = ~sys_clock;  // 8 ns period

    always @(posedge sys_clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // x^16 + x^14 + x^13 + x^11, maximal length
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic random_address(output logic [15:0] addr);
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            addr       = {addr[14:0], lfsr_state[0]};  // One step per bit
        end
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic apply_reset();
        @(negedge sys_clock);
        reset = 1'b1;
        repeat (10) @(negedge sys_clock);
        reset = 1'b0;
    endtask

    `include "pet_bus_tests.svh"

    initial begin
        reset    = 1'b1;
        cpu_be   = 1'b0;
        cpu_phi2 = 1'b0;
        cpu_rw   = 1'b1;
        cpu_addr = '0;
        cpu_data = '0;
        apply_reset();
        reset_and_map_decode();
        write_cycles();
        bus_disabled();
        expansion_banks();
        protect_and_peek();
        reset_clears_expansion();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== logic/pet_bus_top.sv ====
// PET bus decoding top level
// Connects the bus cycle control to the expansion register and the
// address decoder

`timescale 1ns/1ns

`include "pet_consts.svh"

module pet_bus_top (
    input  logic                           sys_clock_i,
    input  logic                           reset_i,
    input  logic                           cpu_be_i,
    input  logic                           cpu_phi2_i,
    input  logic                           cpu_rw_i,    // 1 means read
    input  logic [`PET_ADDR_WIDTH-1:0]     cpu_addr_i,
    input  logic [`PET_DATA_WIDTH-1:0]     cpu_data_i,
    output logic [`PET_RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output logic                           ram_oe_o,
    output logic                           ram_we_o,
    output logic                           ram_en_o,
    output logic                           is_vram_o,
    output logic                           is_readonly_o,
    output logic                           sid_en_o,
    output logic                           pia1_en_o,
    output logic                           pia2_en_o,
    output logic                           via_en_o,
    output logic                           crtc_en_o,
    output logic                           io_en_o
);
    logic             cpu_wr_strobe;
    logic             bank_en;
    logic             bank_a15;
    logic             bank_ro;
    pet_pkg::device_t device;

    bus_cycle_control u_bus_cycle_control (
        .sys_clock_i     (sys_clock_i),
        .reset_i         (reset_i),
        .cpu_be_i        (cpu_be_i),
        .cpu_phi2_i      (cpu_phi2_i),
        .cpu_rw_i        (cpu_rw_i),
        .device_i        (device),
        .is_readonly_i   (is_readonly_o),
        .cpu_wr_strobe_o (cpu_wr_strobe),
        .cycle_active_o  (),
        .ram_oe_o        (ram_oe_o),
        .ram_we_o        (ram_we_o)
    );

    memory_control u_memory_control (
        .sys_clock_i     (sys_clock_i),
        .reset_i         (reset_i),
        .cpu_wr_strobe_i (cpu_wr_strobe),
        .cpu_addr_i      (cpu_addr_i),
        .cpu_data_i      (cpu_data_i),
        .bank_en_o       (bank_en),
        .bank_a15_o      (bank_a15),
        .bank_ro_o       (bank_ro)
    );

    address_decoding u_address_decoding (
        .cpu_be_i      (cpu_be_i),
        .cpu_addr_i    (cpu_addr_i),
        .bank_en_i     (bank_en),
        .bank_a15_i    (bank_a15),
        .bank_ro_i     (bank_ro),
        .device_o      (device),
        .ram_en_o      (ram_en_o),
        .sid_en_o      (sid_en_o),
        .pia1_en_o     (pia1_en_o),
        .pia2_en_o     (pia2_en_o),
        .via_en_o      (via_en_o),
        .crtc_en_o     (crtc_en_o),
        .io_en_o       (io_en_o),
        .is_vram_o     (is_vram_o),
        .is_readonly_o (is_readonly_o),
        .ram_addr_o    (ram_addr_o)
    );

endmodule

// ==== address_decoding/address_decoding.sv ====
// PET address decoder
// Turns the CPU address into a device selection, the device enables,
// the read-only and screen flags and the 17-bit RAM address.
// Expansion banks override the normal PET memory map.

`timescale 1ns/1ns

`include "pet_consts.svh"

module address_decoding (
    input  logic                           cpu_be_i,
    input  logic [`PET_ADDR_WIDTH-1:0]     cpu_addr_i,
    input  logic                           bank_en_i,
    input  logic                           bank_a15_i,
    input  logic                           bank_ro_i,
    output pet_pkg::device_t               device_o,
    output logic                           ram_en_o,
    output logic                           sid_en_o,
    output logic                           pia1_en_o,
    output logic                           pia2_en_o,
    output logic                           via_en_o,
    output logic                           crtc_en_o,
    output logic                           io_en_o,
    output logic                           is_vram_o,
    output logic                           is_readonly_o,
    output logic [`PET_RAM_ADDR_WIDTH-1:0] ram_addr_o
);
    pet_pkg::device_t select;

    always_comb begin
        if (!cpu_be_i) begin
            select = pet_pkg::dev_none;  // Bus released
        end else if (bank_en_i) begin
            select = bank_ro_i ? pet_pkg::dev_rom : pet_pkg::dev_ram;
        end else begin
            // SID must win over the VRAM pattern it overlaps
            priority casez (cpu_addr_i)
                16'b0???_????_????_????: select = pet_pkg::dev_ram;   // $0000 to $7FFF
                16'b1000_1111_????_????: select = pet_pkg::dev_sid;   // $8F00 to $8FFF
                16'b1000_????_????_????: select = pet_pkg::dev_vram;  // $8000 to $8EFF
                16'b1110_1000_0001_????: select = pet_pkg::dev_pia1;  // $E810 to $E81F
                16'b1110_1000_001?_????: select = pet_pkg::dev_pia2;  // $E820 to $E83F
                16'b1110_1000_01??_????: select = pet_pkg::dev_via;   // $E840 to $E87F
                16'b1110_1000_1???_????: select = pet_pkg::dev_crtc;  // $E880 to $E8FF
                default:                 select = pet_pkg::dev_rom;   // Everything else
            endcase
        end
    end

    always_comb begin
        ram_en_o      = 1'b0;
        sid_en_o      = 1'b0;
        pia1_en_o     = 1'b0;
        pia2_en_o     = 1'b0;
        via_en_o      = 1'b0;
        crtc_en_o     = 1'b0;
        io_en_o       = 1'b0;
        is_vram_o     = 1'b0;
        is_readonly_o = 1'b0;

        case (select)
            pet_pkg::dev_ram: begin
                ram_en_o = 1'b1;
            end
            pet_pkg::dev_vram: begin
                ram_en_o  = 1'b1;
                is_vram_o = 1'b1;
            end
            pet_pkg::dev_rom: begin
                ram_en_o      = 1'b1;  // ROM image sits in the RAM array
                is_readonly_o = 1'b1;
            end
            pet_pkg::dev_sid: begin
                sid_en_o = 1'b1;  // Internal, not on the IO bus
            end
            pet_pkg::dev_pia1: begin
                pia1_en_o = 1'b1;
                io_en_o   = 1'b1;
            end
            pet_pkg::dev_pia2: begin
                pia2_en_o = 1'b1;
                io_en_o   = 1'b1;
            end
            pet_pkg::dev_via: begin
                via_en_o = 1'b1;
                io_en_o  = 1'b1;
            end
            pet_pkg::dev_crtc: begin
                crtc_en_o = 1'b1;  // Internal, not on the IO bus
            end
            default: ;
        endcase
    end

    assign device_o = select;

    // Bit 16 picks the expansion half, bit 15 the bank within it
    assign ram_addr_o = {bank_en_i,
                         bank_en_i ? bank_a15_i : cpu_addr_i[15],
                         cpu_addr_i[14:0]};

endmodule

// ==== address_decoding/memory_control.sv ====
// RAM expansion control
// Holds the expansion register at $FFF0 and maps $8000 to $FFFF onto
// the selected 32 KB expansion banks, with optional write protection

`timescale 1ns/1ns

`include "pet_consts.svh"

module memory_control (
    input  logic                       sys_clock_i,
    input  logic                       reset_i,
    input  logic                       cpu_wr_strobe_i,
    input  logic [`PET_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [`PET_DATA_WIDTH-1:0] cpu_data_i,
    output logic                       bank_en_o,
    output logic                       bank_a15_o,
    output logic                       bank_ro_o
);
    logic [`PET_DATA_WIDTH-1:0] mem_ctl;
    logic                       screen_peek;  // Screen stays visible
    logic                       io_peek;      // IO stays visible

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            mem_ctl <= '0;  // Expansion disabled
        end else if (cpu_wr_strobe_i && (cpu_addr_i == `PET_MEM_CTL_ADDR)) begin
            mem_ctl <= cpu_data_i;
        end
    end

    // Peek-through windows punch holes in the banks
    always_comb begin
        screen_peek = 1'b0;
        io_peek     = 1'b0;
        casez (cpu_addr_i)
            16'b1000_????_????_????: screen_peek = mem_ctl[`PET_MEM_CTL_SCREEN_PEEK];
            16'b1110_1???_????_????: io_peek     = mem_ctl[`PET_MEM_CTL_IO_PEEK];
            default: ;
        endcase
    end

    always_comb begin
        bank_en_o  = 1'b0;
        bank_a15_o = 1'b0;
        bank_ro_o  = 1'b0;

        if (mem_ctl[`PET_MEM_CTL_ENABLE]) begin
            casez (cpu_addr_i)
                16'b10??_????_????_????: begin  // Lower bank, $8000 to $BFFF
                    bank_en_o = !screen_peek;
                    if (!screen_peek) begin
                        bank_a15_o = mem_ctl[`PET_MEM_CTL_SELECT_LO];
                        bank_ro_o  = mem_ctl[`PET_MEM_CTL_WRITE_PROTECT_LO];
                    end
                end
                16'b11??_????_????_????: begin  // Upper bank, $C000 to $FFFF
                    bank_en_o = !io_peek;
                    if (!io_peek) begin
                        bank_a15_o = mem_ctl[`PET_MEM_CTL_SELECT_HI];
                        bank_ro_o  = mem_ctl[`PET_MEM_CTL_WRITE_PROTECT_HI];
                    end
                end
                default: ;  // Below $8000 is never banked
            endcase
        end
    end

endmodule

// ==== logic/bus_cycle_control.sv ====
// Bus cycle control
// Follows the phi2 phase, issues a one-cycle write strobe at the end
// of a CPU write and qualifies the RAM read and write enables

`timescale 1ns/1ns

module bus_cycle_control (
    input  logic             sys_clock_i,
    input  logic             reset_i,
    input  logic             cpu_be_i,
    input  logic             cpu_phi2_i,
    input  logic             cpu_rw_i,
    input  pet_pkg::device_t device_i,
    input  logic             is_readonly_i,
    output logic             cpu_wr_strobe_o,
    output logic             cycle_active_o,
    output logic             ram_oe_o,
    output logic             ram_we_o
);
    pet_pkg::cycle_state_t state;
    logic                  phi2_q;      // phi2 seen on the previous edge
    logic                  phi2_rise;
    logic                  phi2_fall;
    logic                  ram_write_target;
    logic                  ram_read_target;

    assign phi2_rise = !phi2_q && cpu_phi2_i;
    assign phi2_fall = phi2_q && !cpu_phi2_i;

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            phi2_q          <= 1'b0;
            state           <= pet_pkg::cycle_idle;
            cpu_wr_strobe_o <= 1'b0;
        end else begin
            phi2_q          <= cpu_phi2_i;
            cpu_wr_strobe_o <= 1'b0;  // Pulse lasts one cycle only

            case (state)
                pet_pkg::cycle_idle: begin
                    if (phi2_rise) begin
                        state <= pet_pkg::cycle_active;
                    end
                end
                pet_pkg::cycle_active: begin
                    if (phi2_fall) begin
                        state           <= pet_pkg::cycle_idle;
                        cpu_wr_strobe_o <= !cpu_rw_i && cpu_be_i;  // End of write cycle
                    end
                end
                default: begin
                    state <= pet_pkg::cycle_idle;
                end
            endcase
        end
    end

    assign cycle_active_o = (state == pet_pkg::cycle_active);

    // Writes only land in RAM or screen memory
    assign ram_write_target = (device_i == pet_pkg::dev_ram)
                           || (device_i == pet_pkg::dev_vram);

    // ROM lives in the same RAM array, so reads include it
    assign ram_read_target  = ram_write_target
                           || (device_i == pet_pkg::dev_rom);

    assign ram_we_o = cpu_wr_strobe_o && ram_write_target && !is_readonly_i;
    assign ram_oe_o = cycle_active_o && cpu_rw_i && ram_read_target;

endmodule

// ==== common/pet_pkg.sv ====
// PET bus decoding types
// State of the CPU bus cycle tracker and the device
// chosen by the address decoder

package pet_pkg;

    // Bus cycle phase as followed from phi2
    typedef enum logic {
        cycle_idle   = 1'b0,  // phi2 low
        cycle_active = 1'b1   // phi2 high
    } cycle_state_t;

    // Device selected for the current address
    typedef enum logic [3:0] {
        dev_none = 4'd0,   // Bus not enabled
        dev_ram  = 4'd1,   // Main or expansion RAM
        dev_vram = 4'd2,   // Screen memory
        dev_rom  = 4'd3,   // ROM or write-protected RAM
        dev_sid  = 4'd4,   // Sound chip
        dev_pia1 = 4'd5,
        dev_pia2 = 4'd6,
        dev_via  = 4'd7,
        dev_crtc = 4'd8    // Video controller
    } device_t;

endpackage

// ==== common/pet_consts.svh ====
// PET bus decoding constants
// Bus widths, the RAM expansion register address and the bit
// positions inside that register

`ifndef PET_CONSTS_SVH
`define PET_CONSTS_SVH

// CPU bus widths
`define PET_ADDR_WIDTH      16
`define PET_DATA_WIDTH      8

// RAM address, 128 KB with the expansion banks
`define PET_RAM_ADDR_WIDTH  17

// RAM expansion register location
`define PET_MEM_CTL_ADDR    16'hFFF0

// Expansion register bits
`define PET_MEM_CTL_ENABLE              7   // Expansion on
`define PET_MEM_CTL_IO_PEEK             6   // Keep IO visible at $E800
`define PET_MEM_CTL_SCREEN_PEEK         5   // Keep screen visible at $8000
`define PET_MEM_CTL_SELECT_HI           3   // Upper bank select, 2 or 3
`define PET_MEM_CTL_SELECT_LO           2   // Lower bank select, 0 or 1
`define PET_MEM_CTL_WRITE_PROTECT_HI    1   // Upper bank read-only
`define PET_MEM_CTL_WRITE_PROTECT_LO    0   // Lower bank read-only

// Bits 4 is unused in the expansion register and
// reads back whatever the CPU last wrote there

`endif
